//--- Makefile
# Verilator build and run for the rf_dual_core testbench

VERILATOR ?= verilator
TOP       ?= rf_dual_core_tb
FILELIST  ?= rf_dual_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/rf_alu_lane.sv
// combinational execution lane: one lane_op_t and two operands in, result and write flag out
module rf_alu_lane #(
   parameter int RW = rf_arch_pkg::WORD_W_DEFAULT   // operand and result width
) (
   input  rf_isa_pkg::lane_op_t op,       // decoded from the captured bundle
   input  logic [RW-1:0]        opa,      // rs1 value, zero if unused
   input  logic [RW-1:0]        opb,      // rs2 value, zero if unused
   output logic [RW-1:0]        result,
   output logic                 wr        // result goes to rd
);

   import rf_isa_pkg::*;

   logic [RW-1:0] sum;
   logic [RW-1:0] diff;

   // both wrap modulo 2**RW
   assign sum  = opa + opb;
   assign diff = opa - opb;

   // ######################################
   // opcode decode
   // ######################################

   always_comb begin
      result = '0;
      wr     = 1'b1;   // every real opcode writes
      case (op.opcode)
         op_ldi: result = RW'(op.imm);   // zero-extend
         op_add: result = sum;
         op_sub: result = diff;
         op_xor: result = opa ^ opb;
         op_and: result = opa & opb;
         default: begin
            // nop and the unused codes
            result = '0;
            wr     = 1'b0;
         end
      endcase
   end

endmodule

//--- design/rf_arch_pkg.sv
// register file geometry and word types, imported by the datapath, control and top level
package rf_arch_pkg;

   // ######################################
   // geometry defaults
   // ######################################

   localparam int REGS_DEFAULT   = 16;   // architectural registers
   localparam int WORD_W_DEFAULT = 32;   // register word width

   // issue width, one write port per lane
   // and two read ports per lane (rs1, rs2)
   localparam int LANES = 2;

   // derived index width
   localparam int IDX_W = $clog2(REGS_DEFAULT);

   // ######################################
   // word level types
   // ######################################

   typedef logic [IDX_W-1:0] reg_idx_t;            // register index, 4 bits
   typedef logic [WORD_W_DEFAULT-1:0] word_t;      // register word

endpackage

//--- design/rf_dual_core.sv
// dual-issue execution subsystem top: joins issue control, register file and both ALU lanes
module rf_dual_core #(
   parameter int REGS = rf_arch_pkg::REGS_DEFAULT,     // register count
   parameter int RW   = rf_arch_pkg::WORD_W_DEFAULT    // word width
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                req,            // four-phase request
   output logic                ack,
   input  rf_isa_pkg::bundle_t bundle,         // stable while req high
   output rf_isa_pkg::retire_t retire,         // held until next retire
   output logic                retire_valid    // one cycle per bundle
);

   import rf_arch_pkg::*;
   import rf_isa_pkg::*;

   localparam int RP = 2 * LANES;   // rs1, rs2 per lane
   localparam int WP = LANES;       // one write per lane

   // ######################################
   // interconnect
   // ######################################

   lane_op_t [LANES-1:0]        lane_op;
   logic [LANES-1:0][RW-1:0]    lane_result;
   logic [LANES-1:0]            lane_wr;
   logic [RP-1:0]               rd_valid;
   reg_idx_t [RP-1:0]           rd_addr;
   logic [RP-1:0][RW-1:0]       rd_data;
   logic [WP-1:0]               wr_valid;
   reg_idx_t [WP-1:0]           wr_addr;
   logic [WP-1:0][RW-1:0]       wr_data;

   rf_issue_ctrl #(.RW(RW)) i_ctrl (
      .clk, .reset, .req, .ack, .bundle, .retire, .retire_valid,
      .lane_op, .lane_result, .lane_wr,
      .rd_valid, .rd_addr,
      .wr_valid, .wr_addr, .wr_data
   );

   rf_regfile #(.REGS(REGS), .RW(RW), .RP(RP), .WP(WP)) i_regfile (
      .clk,
      .wr_valid, .wr_addr, .wr_data,
      .rd_valid, .rd_addr, .rd_data
   );

   // lane i takes read ports 2i (rs1) and 2i+1 (rs2)
   for (genvar i = 0; i < LANES; i++) begin : g_lane
      rf_alu_lane #(.RW(RW)) i_alu (
         .op     (lane_op[i]),
         .opa    (rd_data[2*i]),
         .opb    (rd_data[2*i+1]),
         .result (lane_result[i]),
         .wr     (lane_wr[i])
      );
   end

endmodule

//--- design/rf_isa_pkg.sv
// operation encoding, bundle and retire record types for the dual-issue core and its host
package rf_isa_pkg;

   import rf_arch_pkg::*;

   // ######################################
   // opcodes
   // ######################################

   // 3-bit encoding, codes 6 and 7 unused
   typedef enum logic [2:0] {
      op_nop = 3'd0,   // no operation, no write
      op_ldi = 3'd1,   // rd = zext(imm)
      op_add = 3'd2,   // rd = rs1 + rs2
      op_sub = 3'd3,   // rd = rs1 - rs2
      op_xor = 3'd4,   // rd = rs1 ^ rs2
      op_and = 3'd5    // rd = rs1 & rs2
   } opcode_t;

   // one lane's operation, 31 bits
   typedef struct packed {
      opcode_t     opcode;
      reg_idx_t    rd;
      reg_idx_t    rs1;
      reg_idx_t    rs2;
      logic [15:0] imm;      // zero-extended by ldi
   } lane_op_t;

   // lane 0 in the low element, 62 bits
   typedef lane_op_t [LANES-1:0] bundle_t;

   // ######################################
   // retire record
   // ######################################

   typedef struct packed {
      reg_idx_t rd;       // destination
      word_t    result;   // value written
   } retire_lane_t;

   typedef struct packed {
      logic [LANES-1:0]         wr_mask;   // lane wrote a register
      retire_lane_t [LANES-1:0] lane;
   } retire_t;

endpackage

//--- design/rf_issue_ctrl.sv
// issue control: four-phase handshake, bundle capture, regfile port steering and retire record
module rf_issue_ctrl #(
   parameter int RW = rf_arch_pkg::WORD_W_DEFAULT   // word width on the write path
) (
   input  logic                                                    clk,
   input  logic                                                    reset,
   // host side
   input  logic                                                    req,
   output logic                                                    ack,
   input  rf_isa_pkg::bundle_t                                     bundle,
   output rf_isa_pkg::retire_t                                     retire,
   output logic                                                    retire_valid,
   // lanes
   output rf_isa_pkg::lane_op_t [rf_arch_pkg::LANES-1:0]           lane_op,
   input  logic [rf_arch_pkg::LANES-1:0][RW-1:0]                   lane_result,
   input  logic [rf_arch_pkg::LANES-1:0]                           lane_wr,
   // regfile read ports
   output logic [2*rf_arch_pkg::LANES-1:0]                         rd_valid,
   output rf_arch_pkg::reg_idx_t [2*rf_arch_pkg::LANES-1:0]        rd_addr,
   // regfile write ports, lane 1 on port 1
   output logic [rf_arch_pkg::LANES-1:0]                           wr_valid,
   output rf_arch_pkg::reg_idx_t [rf_arch_pkg::LANES-1:0]          wr_addr,
   output logic [rf_arch_pkg::LANES-1:0][RW-1:0]                   wr_data
);

   import rf_arch_pkg::*;
   import rf_isa_pkg::*;

   typedef enum logic [1:0] {
      st_idle = 2'd0,   // waiting for req
      st_exec = 2'd1,   // operands read, lanes compute
      st_wait = 2'd2    // ack high, waiting for req low
   } state_t;

   state_t  state;
   bundle_t bundle_q;   // captured bundle
   logic    capture;

   // true when the opcode reads rs1 and rs2
   function automatic logic reads_sources(opcode_t opc);
      logic used;
      case (opc)
         op_add, op_sub, op_xor, op_and: used = 1'b1;
         default: used = 1'b0;   // ldi, nop
      endcase
      return used;
   endfunction

   assign capture = (state == st_idle) && req && !ack;

   // ######################################
   // handshake FSM
   // ######################################

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= st_idle;
         ack          <= 1'b0;
         retire_valid <= 1'b0;
      end else begin
         retire_valid <= 1'b0;   // single cycle pulse
         case (state)
            st_idle: if (capture) state <= st_exec;
            st_exec: begin
               state        <= st_wait;   // writes land on this edge
               ack          <= 1'b1;
               retire_valid <= 1'b1;
            end
            st_wait: begin
               if (!req) begin
                  ack   <= 1'b0;   // release seen
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // payload registers
   always_ff @(posedge clk) begin
      if (capture) bundle_q <= bundle;
      if (state == st_exec) begin
         retire.wr_mask <= lane_wr;   // nop lanes give 0
         for (int i = 0; i < LANES; i++) begin
            retire.lane[i].rd     <= bundle_q[i].rd;
            retire.lane[i].result <= lane_result[i];
         end
      end
   end

   // ######################################
   // port steering
   // ######################################

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         lane_op[i]        = bundle_q[i];
         // ports 2i and 2i+1 carry this lane's rs1, rs2
         rd_addr[2*i]      = bundle_q[i].rs1;
         rd_addr[2*i+1]    = bundle_q[i].rs2;
         rd_valid[2*i]     = reads_sources(bundle_q[i].opcode);
         rd_valid[2*i+1]   = reads_sources(bundle_q[i].opcode);
         // write back in exec only, regfile gives lane 1 priority
         wr_valid[i]       = (state == st_exec) && lane_wr[i];
         wr_addr[i]        = bundle_q[i].rd;
         wr_data[i]        = lane_result[i];
      end
   end

endmodule

//--- design/rf_regfile.sv
// multi-port register file: WP write ports, RP read ports with zero latency and valid gating
module rf_regfile #(
   parameter int REGS = 16,   // number of registers
   parameter int RW   = 32,   // register width
   parameter int RP   = 4,    // read ports
   parameter int WP   = 2     // write ports
) (
   input  logic                              clk,
   // write ports
   input  logic [WP-1:0]                     wr_valid,   // per port write strobe
   input  rf_arch_pkg::reg_idx_t [WP-1:0]    wr_addr,
   input  logic [WP-1:0][RW-1:0]             wr_data,
   // read ports
   input  logic [RP-1:0]                     rd_valid,   // low forces zero data
   input  rf_arch_pkg::reg_idx_t [RP-1:0]    rd_addr,
   output logic [RP-1:0][RW-1:0]             rd_data
);

   logic [RW-1:0] mem [REGS];        // storage, no reset
   logic [WP-1:0] write_en [REGS];   // per register, per port

   // ######################################
   // write ports
   // ######################################

   // address decode per register
   always_comb begin
      for (int i = 0; i < REGS; i++) begin
         for (int j = 0; j < WP; j++) begin
            write_en[i][j] = wr_valid[j] && (wr_addr[j] == i);
         end
      end
   end

   // later port overrides earlier in the loop,
   // so the highest port index wins a collision
   always_ff @(posedge clk) begin
      for (int i = 0; i < REGS; i++) begin
         for (int j = 0; j < WP; j++) begin
            if (write_en[i][j]) begin
               mem[i] <= wr_data[j];
            end
         end
      end
   end

   // ######################################
   // read ports
   // ######################################

   // old contents until the write edge
   always_comb begin
      for (int k = 0; k < RP; k++) begin
         rd_data[k] = rd_valid[k] ? mem[rd_addr[k]] : '0;   // unused operand reads zero
      end
   end

endmodule

//--- rf_dual_core.f
design/rf_arch_pkg.sv
design/rf_isa_pkg.sv
design/rf_regfile.sv
design/rf_alu_lane.sv
design/rf_issue_ctrl.sv
design/rf_dual_core.sv
tb/rf_dual_core_asserts.sv
tb/rf_dual_core_tb.sv

//--- tb/rf_dual_core_asserts.sv
// handshake protocol checks for rf_dual_core, bound into the top level by the testbench
module rf_dual_core_asserts (
   input logic clk,
   input logic reset,
   input logic req,            // host request
   input logic ack,            // DUT acknowledge
   input logic retire_valid    // retire pulse
);

   int failures = 0;   // failed protocol checks so far

   // ########################################
   // reset behavior
   // ########################################

   // outputs are quiet in the cycle after reset
   reset_quiet: assert property (@(posedge clk) reset |=> (!ack && !retire_valid))
      else begin
         failures++;
         $error("ack or retire_valid high in the cycle after reset");
      end

   // ########################################
   // handshake timing
   // ########################################

   // req rising while idle is the capture edge and ack follows two edges later
   ack_latency: assert property (@(posedge clk) disable iff (reset)
      $rose(req) |-> ##2 $rose(ack))
      else begin
         failures++;
         $error("ack did not rise two edges after bundle capture");
      end

   // retire and ack rise on the same edge in both directions
   retire_with_ack: assert property (@(posedge clk) disable iff (reset)
      $rose(retire_valid) |-> $rose(ack))
      else begin
         failures++;
         $error("retire_valid rose without ack");
      end

   ack_with_retire: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> $rose(retire_valid))
      else begin
         failures++;
         $error("ack rose without retire_valid");
      end

   retire_pulse: assert property (@(posedge clk) disable iff (reset)
      retire_valid |=> !retire_valid)   // single cycle only
      else begin
         failures++;
         $error("retire_valid held for more than one cycle");
      end

   // release only after the host dropped req
   ack_release: assert property (@(posedge clk) disable iff (reset)
      $fell(ack) |-> !$past(req))
      else begin
         failures++;
         $error("ack fell while req was still high");
      end

endmodule

//--- tb/rf_dual_core_tb.sv
// drives bundles into rf_dual_core over req/ack and checks retire against a shadow model
module rf_dual_core_tb;

   import rf_arch_pkg::*;
   import rf_isa_pkg::*;

   localparam int RANDOM_BUNDLES   = 200;
   localparam int DIRECTED_BUNDLES = 23;   // load, readback, collision, hazard, nop
   localparam int CYCLE_LIMIT      = 60 * (RANDOM_BUNDLES + DIRECTED_BUNDLES) + 100;

   logic    clk;
   logic    reset;
   logic    req;
   bundle_t bundle;
   logic    ack;
   retire_t retire;
   logic    retire_valid;

   word_t   shadow [REGS_DEFAULT];   // register contents as the DUT should hold them
   retire_t exp_retire;              // expected record for the bundle in flight
   int      seed;
   int      cycles = 0;

   rf_dual_core i_dut (
      .clk, .reset, .req, .ack, .bundle, .retire, .retire_valid
   );

   bind rf_dual_core rf_dual_core_asserts i_asserts (
      .clk, .reset, .req, .ack, .retire_valid
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;   // period 10

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   // ########################################
   // checks
   // ########################################

   // whole record, mask, destinations and results
   check_retire: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> (retire == exp_retire))
      else report_failure($sformatf("[FAIL] %0t retire mismatch, got %h expected %h",
                                    $time, retire, exp_retire));

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (i_dut.i_asserts.failures != 0) begin
         report_failure("a handshake protocol check failed");
      end else if (cycles >= CYCLE_LIMIT) begin
         report_failure($sformatf("timeout: run did not finish within %0d cycles",
                                  CYCLE_LIMIT));
      end
   end

   // ########################################
   // reference model and stimulus
   // ########################################

   function automatic lane_op_t make_op(opcode_t opc, int rd, int rs1, int rs2,
                                        logic [15:0] imm);
      lane_op_t op;
      op.opcode = opc;
      op.rd     = reg_idx_t'(rd);
      op.rs1    = reg_idx_t'(rs1);
      op.rs2    = reg_idx_t'(rs2);
      op.imm    = imm;
      return op;
   endfunction

   // add, sub, xor or and with r0 never a destination
   function automatic lane_op_t random_op();
      opcode_t opc;
      int      rd;
      int      rs1;
      int      rs2;
      opc = opcode_t'(3'(2 + ($unsigned($random(seed)) % 4)));
      rd  = 1 + ($unsigned($random(seed)) % 15);
      rs1 = $unsigned($random(seed)) % 16;
      rs2 = $unsigned($random(seed)) % 16;
      return make_op(opc, rd, rs1, rs2, 16'($random(seed)));
   endfunction

   // result from the shadow contents before this bundle
   function automatic word_t model_result(lane_op_t op);
      word_t a;
      word_t b;
      word_t r;
      a = shadow[op.rs1];
      b = shadow[op.rs2];
      case (op.opcode)
         op_ldi:  r = word_t'(op.imm);   // zero extended
         op_add:  r = a + b;             // wraps at 2**32
         op_sub:  r = a - b;
         op_xor:  r = a ^ b;
         op_and:  r = a & b;
         default: r = '0;                // nop
      endcase
      return r;
   endfunction

   task automatic send_bundle(input lane_op_t op0, input lane_op_t op1);
      bundle_t b;
      retire_t exp;
      word_t   res [LANES];
      b[0] = op0;
      b[1] = op1;
      for (int i = 0; i < LANES; i++) begin
         res[i]             = model_result(b[i]);   // both read old values
         exp.wr_mask[i]     = (b[i].opcode != op_nop);
         exp.lane[i].rd     = b[i].rd;
         exp.lane[i].result = res[i];
      end
      // writes after all reads with lane 1 last so it wins
      for (int i = 0; i < LANES; i++) begin
         if (exp.wr_mask[i]) shadow[b[i].rd] = res[i];
      end
      @(negedge clk);
      exp_retire = exp;
      bundle     = b;
      req        = 1'b1;
      while (!ack) @(negedge clk);   // results written
      req = 1'b0;
      while (ack) @(negedge clk);    // release seen
   endtask

   initial begin
      seed   = 32'h7ce0685f;
      reset  = 1'b1;
      req    = 1'b0;
      bundle = '0;
      exp_retire = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // load every register with r0 getting zero
      for (int k = 0; k < REGS_DEFAULT / 2; k++) begin
         send_bundle(make_op(op_ldi, 2*k, 0, 0, (k == 0) ? 16'h0 : 16'($random(seed))),
                     make_op(op_ldi, 2*k+1, 0, 0, 16'($random(seed))));
      end
      // read back through add with r0
      for (int k = 0; k < REGS_DEFAULT / 2; k++) begin
         send_bundle(make_op(op_add, 2*k, 2*k, 0, 16'h0),
                     make_op(op_add, 2*k+1, 2*k+1, 0, 16'h0));
      end

      for (int n = 0; n < RANDOM_BUNDLES; n++) begin
         send_bundle(random_op(), random_op());
      end

      // same destination on both lanes keeps lane 1
      send_bundle(make_op(op_ldi, 5, 0, 0, 16'h1111), make_op(op_ldi, 5, 0, 0, 16'h2222));
      send_bundle(make_op(op_add, 6, 5, 0, 16'h0), make_op(op_nop, 0, 0, 0, 16'h0));

      // lane 1 sees old r7 and the next bundle sees the new one
      send_bundle(make_op(op_ldi, 7, 0, 0, 16'habcd), make_op(op_add, 8, 7, 0, 16'h0));
      send_bundle(make_op(op_add, 9, 7, 0, 16'h0), make_op(op_add, 10, 8, 0, 16'h0));

      // nop lanes give a zero mask and change nothing
      send_bundle(make_op(op_nop, 3, 1, 2, 16'hffff), make_op(op_nop, 4, 1, 2, 16'hffff));
      send_bundle(make_op(op_nop, 11, 0, 0, 16'h0), make_op(op_add, 12, 3, 4, 16'h0));
      send_bundle(make_op(op_add, 3, 3, 0, 16'h0), make_op(op_xor, 4, 4, 0, 16'h0));

      repeat (4) @(negedge clk);
      if (i_dut.i_asserts.failures == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         report_failure("a handshake protocol check failed");
      end
   end

endmodule
